//--- project.f
+incdir+source
source/tenyr_pkg.sv
source/data_ram.sv
source/mmr.sv
source/seg7_scan.sv
source/io_block.sv
source/bus_join.sv
source/tenyr_soc.sv
sim/clk_gen.sv
sim/tenyr_soc_assertions.sv
sim/tenyr_soc_tb.sv

//--- sim/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tenyr_soc_assertions.sv
`default_nettype none

module tenyr_soc_assertions (
    input wire                   clk,
    input wire                   rst,
    input wire                   req_valid,
    input wire                   req_write,
    input wire                   rsp_valid,
    input wire tenyr_pkg::word_t rsp_rdata,
    input wire [3:0]             an
);

    timeunit 1ns;
    timeprecision 100ps;

    // A response only follows a read request one cycle earlier
    rsp_after_read: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> $past(req_valid && !req_write))
        else $error("rsp_valid without a read request in the previous cycle");

    rsp_data_known: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !$isunknown(rsp_rdata))
        else $error("rsp_rdata has unknown bits while rsp_valid is high");

    anode_one_low: assert property (@(posedge clk) disable iff (rst)
        $onehot0(~an))
        else $error("more than one anode line is low");

endmodule

`default_nettype wire

//--- sim/tenyr_soc_tb.sv
`default_nettype none

`include "tenyr_settings.svh"

module tenyr_soc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;    // Cycles per wait loop

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_write;
    tenyr_pkg::addr_t   req_addr;
    tenyr_pkg::word_t   req_wdata;
    tenyr_pkg::word_t   rsp_rdata;
    logic               rsp_valid;
    logic [7:0]         seg;
    logic [3:0]         an;
    tenyr_pkg::ctl_t    vga_ctl;
    tenyr_pkg::cursor_t cursor_x;
    tenyr_pkg::cursor_t cursor_y;

    int errors = 0;
    int checks = 0;
    int timeouts = 0;

    tenyr_pkg::word_t ram_model [int];    // Only written words are known
    logic [7:0]       vid_model [3];      // ctl, cursor x, cursor y
    logic [15:0]      seg_model;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    tenyr_soc u_dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .rsp_rdata(rsp_rdata), .rsp_valid(rsp_valid),
        .seg(seg), .an(an),
        .vga_ctl(vga_ctl), .cursor_x(cursor_x), .cursor_y(cursor_y)
    );

    bind tenyr_soc tenyr_soc_assertions u_assertions (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_write(req_write),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .an(an)
    );

    // Active low, DP off in bit 7, segment a in bit 0
    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    task automatic check_word(input string what, input tenyr_pkg::word_t got,
                              input tenyr_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Called and returns on a falling edge
    task automatic bus_write(input tenyr_pkg::addr_t addr, input tenyr_pkg::word_t data);
        req_valid = 1'b1;
        req_write = 1'b1;
        req_addr  = addr;
        req_wdata = data;
        @(negedge clk);
        req_valid = 1'b0;
        req_write = 1'b0;
    endtask

    task automatic bus_read(input tenyr_pkg::addr_t addr, output tenyr_pkg::word_t data);
        int n;
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr  = addr;
        @(negedge clk);
        req_valid = 1'b0;
        data = 'x;
        for (n = 0; n < WAIT_LIMIT && !rsp_valid; n++) begin
            @(negedge clk);
        end
        if (rsp_valid) begin
            data = rsp_rdata;
        end else begin
            timeouts++;
            $display("Timeout: no read response for address %h", addr);
        end
    endtask

    task automatic read_check(input tenyr_pkg::addr_t addr, input tenyr_pkg::word_t exp,
                              input string what);
        tenyr_pkg::word_t data;
        bus_read(addr, data);
        check_word(what, data, exp);
    endtask

    task automatic check_io_state(input string what);
        checks++;
        if (vga_ctl !== vid_model[0] || cursor_x !== vid_model[1]
            || cursor_y !== vid_model[2]) begin
            errors++;
            $display("[ERROR] %0t ns: %s ports ctl=%h x=%h y=%h, expected %h %h %h", $time,
                     what, vga_ctl, cursor_x, cursor_y, vid_model[0], vid_model[1],
                     vid_model[2]);
        end
        read_check(`VIDEO_ADDR, 32'(vid_model[0]), {what, " ctl readback"});
        read_check(`VIDEO_ADDR + 32'd1, 32'(vid_model[1]), {what, " cursor x readback"});
        read_check(`VIDEO_ADDR + 32'd2, 32'(vid_model[2]), {what, " cursor y readback"});
        read_check(`SEG7_ADDR, 32'(seg_model), {what, " display value readback"});
    endtask

    task automatic test_reset();
        checks++;
        if (rsp_valid !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t ns: rsp_valid is %b after reset", $time, rsp_valid);
        end
        check_io_state("after reset");
    endtask

    task automatic test_ram();
        tenyr_pkg::addr_t addr;
        tenyr_pkg::word_t data;
        repeat (12) begin
            addr = $urandom_range(`RAM_DEPTH - 1);
            data = $urandom;
            bus_write(addr, data);
            ram_model[addr] = data;
            read_check(addr, data, "RAM readback");    // Very next request
        end
    endtask

    task automatic test_back_to_back();
        tenyr_pkg::addr_t addrs [4];
        tenyr_pkg::word_t exp [4];
        tenyr_pkg::word_t got [$];
        int k0;
        int k1;
        int c;
        void'(ram_model.first(k0));
        void'(ram_model.last(k1));
        addrs = '{k0, `VIDEO_ADDR, k1, `VIDEO_ADDR + 32'd2};
        exp = '{ram_model[k0], 32'(vid_model[0]), ram_model[k1], 32'(vid_model[2])};
        for (c = 0; c < WAIT_LIMIT && got.size() < 4; c++) begin
            req_valid = (c < 4);
            req_write = 1'b0;
            req_addr  = addrs[c % 4];
            @(negedge clk);
            if (rsp_valid) begin
                checks++;
                if (c != got.size()) begin    // Response k seen one cycle after issue k
                    errors++;
                    $display("[ERROR] %0t ns: response %0d in cycle %0d, expected cycle %0d",
                             $time, got.size(), c, got.size());
                end
                got.push_back(rsp_rdata);
            end
        end
        req_valid = 1'b0;
        if (got.size() < 4) begin
            timeouts++;
            $display("Timeout: only %0d of 4 back-to-back responses arrived", got.size());
        end
        foreach (got[i]) begin
            check_word($sformatf("back-to-back response %0d", i), got[i], exp[i]);
        end
    endtask

    task automatic test_video();
        tenyr_pkg::word_t data;
        for (int i = 0; i < 3; i++) begin
            data = $urandom | 32'h8000_0100;    // Upper bits must be dropped
            bus_write(`VIDEO_ADDR + i, data);
            vid_model[i] = data[7:0];
        end
        check_io_state("video write");
    endtask

    task automatic test_seg7();
        tenyr_pkg::word_t data;
        logic [3:0]       target;
        logic [7:0]       exp;
        int               n;
        data = $urandom;
        bus_write(`SEG7_ADDR, data);
        seg_model = data[15:0];
        read_check(`SEG7_ADDR, 32'(seg_model), "display value readback");
        for (int d = 0; d < 4; d++) begin
            target = ~(4'b0001 << d);
            exp    = hex_seg(seg_model[d*4 +: 4]);
            for (n = 0; n < WAIT_LIMIT && an === target; n++) begin
                @(negedge clk);
            end
            for (n = 0; n < WAIT_LIMIT && an !== target; n++) begin
                @(negedge clk);
            end
            if (an !== target) begin
                timeouts++;
                $display("Timeout: anode for digit %0d never went low", d);
            end
            for (n = 0; n < WAIT_LIMIT && an === target; n++) begin
                checks++;
                if (seg !== exp) begin
                    errors++;
                    $display("[ERROR] %0t ns: digit %0d seg %h, expected %h",
                             $time, d, seg, exp);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic test_unmapped();
        bus_write(32'h0000_0000, 32'h1234_5678);
        ram_model[0] = 32'h1234_5678;
        read_check(32'h0000_2000, '0, "unmapped read");
        bus_write(32'h0000_2000, 32'hDEAD_BEEF);    // Aliases RAM word 0 if undecoded
        bus_write(`VIDEO_ADDR + 32'd3, 32'hDEAD_BEEF);
        read_check(32'h0000_2000, '0, "unmapped read after write");
        foreach (ram_model[k]) begin
            read_check(k, ram_model[k], "RAM after unmapped write");
        end
        check_io_state("unmapped write");
    endtask

    initial begin
        int n;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        void'($urandom(32'h3a7b_620e));
        vid_model = '{tenyr_pkg::CTL_DEFAULT, tenyr_pkg::CRX_DEFAULT, tenyr_pkg::CRY_DEFAULT};
        seg_model = '0;
        @(negedge clk);
        for (n = 0; n < WAIT_LIMIT && rst; n++) begin
            @(negedge clk);
        end
        if (rst) begin
            timeouts++;
            $display("Timeout: reset never released");
        end
        test_reset();
        test_ram();
        test_back_to_back();
        test_video();
        test_seg7();
        test_unmapped();
        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bus_join.sv
`default_nettype none

`include "tenyr_settings.svh"

module bus_join (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire tenyr_pkg::addr_t    req_addr,
    input  wire tenyr_pkg::word_t    req_wdata,
    output logic                     ram_en,
    output logic                     ram_write,
    output tenyr_pkg::addr_t         ram_addr,
    output tenyr_pkg::word_t         ram_wdata,
    input  wire tenyr_pkg::word_t    ram_rdata,
    input  wire tenyr_pkg::word_t    io_rdata,
    output logic                     rsp_valid,
    output tenyr_pkg::word_t         rsp_rdata
);

    logic ram_inrange;
    logic rd_pend;    // Read issued last cycle
    logic rd_ram;     // That read went to the RAM

    assign ram_inrange = req_addr < tenyr_pkg::addr_t'(`RAM_DEPTH);

    assign ram_en    = req_valid && ram_inrange;
    assign ram_write = req_write;
    assign ram_addr  = req_addr;
    assign ram_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rd_ram  <= 1'b0;
        end else begin
            rd_pend <= req_valid && !req_write;
            rd_ram  <= ram_inrange;
        end
    end

    // Both sources have one cycle latency, so the select lines up with the data
    assign rsp_valid = rd_pend;
    assign rsp_rdata = rd_ram ? ram_rdata : io_rdata;

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none

`include "tenyr_settings.svh"

module data_ram (
    input  wire                      clk,
    input  wire                      ram_en,
    input  wire                      ram_write,
    input  wire tenyr_pkg::addr_t    ram_addr,
    input  wire tenyr_pkg::word_t    ram_wdata,
    output tenyr_pkg::word_t         ram_rdata
);

    localparam int AW = $clog2(`RAM_DEPTH);

    tenyr_pkg::word_t mem [`RAM_DEPTH];

    logic [AW-1:0] word_idx;

    assign word_idx = ram_addr[AW-1:0];    // Range check is done upstream

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_write) begin
                mem[word_idx] <= ram_wdata;
            end else begin
                ram_rdata <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/io_block.sv
`default_nettype none

`include "tenyr_settings.svh"

module io_block (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire tenyr_pkg::addr_t    req_addr,
    input  wire tenyr_pkg::word_t    req_wdata,
    output tenyr_pkg::word_t         io_rdata,
    output logic [7:0]               seg,
    output logic [3:0]               an,
    output tenyr_pkg::ctl_t          vga_ctl,
    output tenyr_pkg::cursor_t       cursor_x,
    output tenyr_pkg::cursor_t       cursor_y
);

    logic             seg_hit;
    logic             ctl_hit;
    logic             crx_hit;
    logic             cry_hit;
    logic [15:0]      seg_value;
    tenyr_pkg::word_t rd_next;

    seg7_scan #(.ADDR(`SEG7_ADDR)) u_seg7 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .hit(seg_hit), .value(seg_value), .seg(seg), .an(an)
    );

    mmr #(
        .ADDR(`VIDEO_ADDR), .value_t(tenyr_pkg::ctl_t), .DEFAULT(tenyr_pkg::CTL_DEFAULT)
    ) u_video_ctl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .hit(ctl_hit), .value(vga_ctl)
    );

    mmr #(
        .ADDR(`VIDEO_ADDR + 32'd1), .value_t(tenyr_pkg::cursor_t),
        .DEFAULT(tenyr_pkg::CRX_DEFAULT)
    ) u_crx (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .hit(crx_hit), .value(cursor_x)
    );

    mmr #(
        .ADDR(`VIDEO_ADDR + 32'd2), .value_t(tenyr_pkg::cursor_t),
        .DEFAULT(tenyr_pkg::CRY_DEFAULT)
    ) u_cry (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .hit(cry_hit), .value(cursor_y)
    );

    // Hits are mutually exclusive and no hit means unmapped
    always_comb begin
        if (seg_hit) begin
            rd_next = tenyr_pkg::word_t'(seg_value);
        end else if (ctl_hit) begin
            rd_next = tenyr_pkg::word_t'(vga_ctl);
        end else if (crx_hit) begin
            rd_next = tenyr_pkg::word_t'(cursor_x);
        end else if (cry_hit) begin
            rd_next = tenyr_pkg::word_t'(cursor_y);
        end else begin
            rd_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        io_rdata <= rd_next;    // One cycle read latency, like the RAM
    end

endmodule

`default_nettype wire

//--- source/mmr.sv
`default_nettype none

module mmr #(
    parameter tenyr_pkg::addr_t ADDR    = '0,
    parameter type              value_t = logic [7:0],
    parameter value_t           DEFAULT = '0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire tenyr_pkg::addr_t    req_addr,
    input  wire tenyr_pkg::word_t    req_wdata,
    output logic                     hit,
    output value_t                   value
);

    localparam int VW = $bits(value_t);

    logic match;

    assign match = req_valid && (req_addr == ADDR);
    assign hit   = match && !req_write;    // Read select for the parent

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= DEFAULT;
        end else if (match && req_write) begin
            value <= req_wdata[VW-1:0];    // Upper data bits dropped
        end
    end

endmodule

`default_nettype wire

//--- source/seg7_scan.sv
`default_nettype none

`include "tenyr_settings.svh"

module seg7_scan #(
    parameter tenyr_pkg::addr_t ADDR = `SEG7_ADDR
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire tenyr_pkg::addr_t    req_addr,
    input  wire tenyr_pkg::word_t    req_wdata,
    output logic                     hit,
    output logic [15:0]              value,
    output logic [7:0]               seg,
    output logic [3:0]               an
);

    localparam int            DIV_W    = $clog2(`SCAN_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);

    logic             match;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       digit;
    logic [3:0]       nibble;
    logic [6:0]       pattern;    // Active high, a in bit 0

    assign match  = req_valid && (req_addr == ADDR);
    assign hit    = match && !req_write;
    assign nibble = value[digit*4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: pattern = 7'h3F;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5B;
            4'h3: pattern = 7'h4F;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6D;
            4'h6: pattern = 7'h7D;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7F;
            4'h9: pattern = 7'h6F;
            4'hA: pattern = 7'h77;
            4'hB: pattern = 7'h7C;
            4'hC: pattern = 7'h39;
            4'hD: pattern = 7'h5E;
            4'hE: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            value   <= '0;
            div_cnt <= '0;
            digit   <= '0;
            seg     <= '1;    // All segments dark
            an      <= '1;
        end else begin
            if (match && req_write) begin
                value <= req_wdata[15:0];
            end
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
                digit   <= digit + 2'd1;    // Wraps 3 -> 0
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            seg <= {1'b1, ~pattern};    // DP off
            an  <= ~(4'b0001 << digit);
        end
    end

endmodule

`default_nettype wire

//--- source/tenyr_pkg.sv
`default_nettype none

package tenyr_pkg;

    // Bus word and word address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Video register payloads
    typedef logic [7:0] ctl_t;
    typedef logic [7:0] cursor_t;

    localparam ctl_t    CTL_DEFAULT = 8'hF7;
    localparam cursor_t CRX_DEFAULT = 8'd1;    // Cursor X counts from 1
    localparam cursor_t CRY_DEFAULT = 8'd0;

endpackage

`default_nettype wire

//--- source/tenyr_settings.svh
`ifndef TENYR_SETTINGS_SVH
`define TENYR_SETTINGS_SVH

// Data RAM size in 32-bit words, mapped from address 0
`define RAM_DEPTH 1024

// Word address of the display value register
`define SEG7_ADDR 32'h0000_1000

// Video register block with control at base, cursor X at +1 and cursor Y at +2
`define VIDEO_ADDR 32'h0000_1100

// Clocks per lit digit
`define SCAN_DIV 16

`endif

//--- source/tenyr_soc.sv
`default_nettype none

module tenyr_soc (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire tenyr_pkg::addr_t    req_addr,
    input  wire tenyr_pkg::word_t    req_wdata,
    output tenyr_pkg::word_t         rsp_rdata,
    output logic                     rsp_valid,
    output logic [7:0]               seg,
    output logic [3:0]               an,
    output tenyr_pkg::ctl_t          vga_ctl,
    output tenyr_pkg::cursor_t       cursor_x,
    output tenyr_pkg::cursor_t       cursor_y
);

    wire                   ram_en;
    wire                   ram_write;
    wire tenyr_pkg::addr_t ram_addr;
    wire tenyr_pkg::word_t ram_wdata;
    wire tenyr_pkg::word_t ram_rdata;
    wire tenyr_pkg::word_t io_rdata;

    bus_join u_bus_join (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .ram_en(ram_en), .ram_write(ram_write),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata), .io_rdata(io_rdata),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata)
    );

    data_ram u_data_ram (
        .clk(clk),
        .ram_en(ram_en), .ram_write(ram_write),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    // Peripherals see the raw request and decode for themselves
    io_block u_io_block (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .io_rdata(io_rdata),
        .seg(seg), .an(an),
        .vga_ctl(vga_ctl), .cursor_x(cursor_x), .cursor_y(cursor_y)
    );

endmodule

`default_nettype wire
